/* rtl/ahbDecoder.sv */
/*
  Address decoder with the default slave. Addresses outside the TIM window get
  the two-cycle ERROR response. Read data from the default slave is zero.
*/
`timescale 1ns/1ps
`include "tim_cfg.svh"

module ahbDecoder (
  input  logic            HCLK,
  input  logic            HRESETn,
  input  logic            HSEL,
  input  logic [31:0]     HADDR,
  input  tim_pkg::hTransT HTRANS,
  input  logic            HREADY,
  output logic            selTim,
  input  logic [31:0]     timRdata,
  input  logic            timReady,
  output logic [31:0]     HRDATA,
  output logic            HREADYOUT,
  output logic            HRESP
);

  import tim_pkg::*;

  errStateT    errState;
  errStateT    errNext;
  logic [31:0] offset;
  logic        inWindow;
  logic        selErr;
  logic        active;
  logic        errAccept;
  logic        ownerTim;
  logic        errReady;
  logic        errResp;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  // Unsigned wrap makes addresses below the base fail the compare too
  assign offset   = HADDR - `TIM_BASE;
  assign inWindow = (offset < `TIM_BYTES);
  assign selTim   = HSEL & inWindow;
  assign selErr   = HSEL & ~inWindow;

  assign active    = (HTRANS == transNonseq) | (HTRANS == transSeq);
  assign errAccept = selErr & HREADY & active;

  // Owner of the next data phase, taken whenever the bus moves on
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      ownerTim <= 1'b1;
    end else if (HREADY) begin
      ownerTim <= ~errAccept;
    end
  end

  ////////////////////////////////////////
  // Default slave
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      errState <= errIdle;
    end else begin
      errState <= errNext;
    end
  end

  always_comb begin
    errNext = errState;
    case (errState)
      errIdle:   if (errAccept) errNext = errFirst;
      errFirst:  errNext = errSecond;
      // Another bad address in the pipeline restarts the response
      errSecond: errNext = errAccept ? errFirst : errIdle;
      default:   errNext = errIdle;
    endcase
  end

  // ERROR asks for HRESP high on both cycles, ready only on the second
  assign errResp  = (errState == errFirst) | (errState == errSecond);
  assign errReady = (errState != errFirst);

  // Response multiplexer driven by the data-phase owner
  assign HREADYOUT = ownerTim ? timReady : errReady;
  assign HRESP     = ownerTim ? 1'b0 : errResp;
  assign HRDATA    = ownerTim ? timRdata : 32'h0000_0000;

endmodule

/* rtl/dtim.sv */
/*
  Data TIM slave. Always answers OKAY after `TIM_WAIT_STATES wait states;
  the decoder supplies HRESP and the default slave.
*/
`timescale 1ns/1ps

module dtim (
  input  logic            HCLK,
  input  logic            HRESETn,
  input  logic            selTim,
  input  logic            HREADY,
  input  tim_pkg::hTransT HTRANS,
  input  logic            HWRITE,
  input  tim_pkg::hSizeT  HSIZE,
  input  logic [31:0]     HADDR,
  input  logic [31:0]     HWDATA,
  output logic [31:0]     HRDATA,
  output logic            readyOut
);

  logic waitDone;
  logic waitLoad;
  logic capture;
  logic writeEn;

  // Accepts transfers and paces the data phase
  timControl control_i (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .selTim   (selTim),
    .HREADY   (HREADY),
    .HTRANS   (HTRANS),
    .HWRITE   (HWRITE),
    .waitDone (waitDone),
    .waitLoad (waitLoad),
    .capture  (capture),
    .writeEn  (writeEn),
    .readyOut (readyOut)
  );

  waitCounter counter_i (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .load     (waitLoad),
    .waitDone (waitDone)
  );

  // Storage, lane masking and read register
  timArray array_i (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .capture (capture),
    .HADDR   (HADDR),
    .HSIZE   (HSIZE),
    .writeEn (writeEn),
    .HWDATA  (HWDATA),
    .HRDATA  (HRDATA)
  );

endmodule

/* rtl/timArray.sv */
/*
  Data TIM storage with byte-lane writes. Contents are undefined after reset.
  Reads always return the whole word; a write to the word being read is forwarded.
*/
`timescale 1ns/1ps
`include "tim_cfg.svh"

module timArray (
  input  logic           HCLK,
  input  logic           HRESETn,
  input  logic           capture,
  input  logic [31:0]    HADDR,
  input  tim_pkg::hSizeT HSIZE,
  input  logic           writeEn,
  input  logic [31:0]    HWDATA,
  output logic [31:0]    HRDATA
);

  import tim_pkg::*;

  localparam int IdxW = $clog2(`TIM_DEPTH);

  logic [31:0]     mem [`TIM_DEPTH];
  logic [IdxW-1:0] wordIdx;
  logic [IdxW-1:0] readIdx;
  hSizeT           sizeQ;
  logic [1:0]      byteOff;
  logic [3:0]      laneMask;
  logic            forward;

  // Size and byte offset decide the lanes, so they restart as a plain word
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sizeQ   <= sizeWord;
      byteOff <= 2'b00;
    end else if (capture) begin
      sizeQ   <= HSIZE;
      byteOff <= HADDR[1:0];
    end
  end

  always_ff @(posedge HCLK) begin
    if (capture) begin
      wordIdx <= HADDR[IdxW+1:2];
    end
  end

  // Halfwords sit on lanes 0-1 or 2-3, anything wider is a word
  always_comb begin
    case (sizeQ)
      sizeByte: laneMask = 4'b0001 << byteOff;
      sizeHalf: laneMask = 4'b0011 << {byteOff[1], 1'b0};
      default:  laneMask = 4'b1111;
    endcase
  end

  // The address phase reads ahead, which covers the zero-wait case
  assign readIdx = capture ? HADDR[IdxW+1:2] : wordIdx;
  assign forward = writeEn & (readIdx == wordIdx);

  // Write enabled lanes and register the read word for the ready cycle
  always_ff @(posedge HCLK) begin
    for (int i = 0; i < 4; i++) begin
      if (writeEn && laneMask[i]) begin
        mem[wordIdx][8*i +: 8] <= HWDATA[8*i +: 8];
      end
      if (forward && laneMask[i]) begin
        HRDATA[8*i +: 8] <= HWDATA[8*i +: 8];
      end else begin
        HRDATA[8*i +: 8] <= mem[readIdx][8*i +: 8];
      end
    end
  end

endmodule

/* rtl/timControl.sv */
/*
  Transfer control of the data TIM. Assumes HREADY comes back from the owning
  slave, so nothing is accepted while readyOut is low. SEQ is handled as NONSEQ.
*/
`timescale 1ns/1ps
`include "tim_cfg.svh"

module timControl (
  input  logic            HCLK,
  input  logic            HRESETn,
  input  logic            selTim,
  input  logic            HREADY,
  input  tim_pkg::hTransT HTRANS,
  input  logic            HWRITE,
  input  logic            waitDone,
  output logic            waitLoad,
  output logic            capture,
  output logic            writeEn,
  output logic            readyOut
);

  import tim_pkg::*;

  // With no wait states a transfer goes straight to its ready cycle
  localparam ctlStateT StartState = ctlStateT'((`TIM_WAIT_STATES == 0) ? ctlLast : ctlWait);

  ctlStateT state;
  ctlStateT nextState;
  logic     accept;
  logic     writePending;

  ////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////

  // Only NONSEQ and SEQ are real transfers, IDLE and BUSY get no wait states
  assign accept = selTim & HREADY & ((HTRANS == transNonseq) | (HTRANS == transSeq));

  // The array takes address and size, the counter starts, in the same cycle
  assign capture  = accept;
  assign waitLoad = accept;

  // Direction of the transfer that owns the data phase
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      writePending <= 1'b0;
    end else if (accept) begin
      writePending <= HWRITE;
    end
  end

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state <= ctlIdle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      ctlIdle: begin
        if (accept) begin
          nextState = StartState;
        end
      end
      ctlWait: begin
        // The counter marks the last low cycle
        if (waitDone) begin
          nextState = ctlLast;
        end
      end
      ctlLast: begin
        // A pipelined address phase here starts the next transfer at once
        if (accept) begin
          nextState = StartState;
        end else begin
          nextState = ctlIdle;
        end
      end
      default: begin
        nextState = ctlIdle;
      end
    endcase
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // Ready everywhere except the wait states
  assign readyOut = (state != ctlWait);

  // The write lands on the edge that closes the data phase
  assign writeEn = (state == ctlLast) & writePending;

endmodule

/* rtl/timSubsystem.sv */
/*
  Data TIM behind its decoder. In a single-slave system HREADY must be tied
  back from HREADYOUT outside this block.
*/
`timescale 1ns/1ps

module timSubsystem (
  input  logic            HCLK,
  input  logic            HRESETn,
  input  logic            HSEL,
  input  logic [31:0]     HADDR,
  input  logic            HWRITE,
  input  tim_pkg::hTransT HTRANS,
  input  tim_pkg::hSizeT  HSIZE,
  input  logic [31:0]     HWDATA,
  input  logic            HREADY,
  output logic [31:0]     HRDATA,
  output logic            HREADYOUT,
  output logic            HRESP
);

  logic        selTim;
  logic [31:0] timRdata;
  logic        timReady;

  // Decode, default slave and response mux
  ahbDecoder decoder_i (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HREADY    (HREADY),
    .selTim    (selTim),
    .timRdata  (timRdata),
    .timReady  (timReady),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP)
  );

  // The memory slave itself
  dtim dtim_i (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .selTim   (selTim),
    .HREADY   (HREADY),
    .HTRANS   (HTRANS),
    .HWRITE   (HWRITE),
    .HSIZE    (HSIZE),
    .HADDR    (HADDR),
    .HWDATA   (HWDATA),
    .HRDATA   (timRdata),
    .readyOut (timReady)
  );

endmodule

/* rtl/tim_cfg.svh */
/*
  Data TIM window and timing. TIM_BYTES must be a power of two and TIM_BASE
  must be aligned to it, because the word index is taken from the low HADDR bits.
  TIM_WAIT_STATES is 3 bits wide, so 0 to 7 wait states per transfer.
*/
`ifndef TIM_CFG_SVH
`define TIM_CFG_SVH

// First byte address of the memory window
`define TIM_BASE 32'h8000_0000

// Window size in bytes
`define TIM_BYTES 32'd4096

// Number of 32-bit words held in the array
`define TIM_DEPTH (`TIM_BYTES / 4)

// Wait states inserted before the OKAY cycle of every transfer
`define TIM_WAIT_STATES 3'd2

`endif

/* rtl/tim_pkg.sv */
/*
  Enums shared by the data TIM and its decoder. HSIZE above a word is not
  supported and is treated as a word by the array.
*/
package tim_pkg;

  // AHB-Lite HTRANS encodings
  typedef enum logic [1:0] {
    transIdle   = 2'b00,
    transBusy   = 2'b01,
    transNonseq = 2'b10,
    transSeq    = 2'b11
  } hTransT;

  // AHB-Lite HSIZE encodings up to the 32-bit bus width
  typedef enum logic [2:0] {
    sizeByte = 3'b000,
    sizeHalf = 3'b001,
    sizeWord = 3'b010
  } hSizeT;

  // Memory slave control: idle, wait states, final ready cycle
  typedef enum logic [1:0] {ctlIdle, ctlWait, ctlLast} ctlStateT;

  // Default slave: two-cycle ERROR response
  typedef enum logic [1:0] {errIdle, errFirst, errSecond} errStateT;

endpackage

/* rtl/waitCounter.sv */
/*
  Wait-state counter. Loaded in the address phase, so the following cycle
  already counts as the first wait state.
*/
`timescale 1ns/1ps
`include "tim_cfg.svh"

module waitCounter (
  input  logic HCLK,
  input  logic HRESETn,
  input  logic load,
  output logic waitDone
);

  // The address-phase cycle is not a wait state, so one is taken off here
  // Zero wait states leave the count at zero and waitDone stays high
  localparam logic [2:0] LoadValue =
    (`TIM_WAIT_STATES == 0) ? 3'd0 : 3'(`TIM_WAIT_STATES - 3'd1);

  logic [2:0] count;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      count <= 3'd0;
    end else if (load) begin
      count <= LoadValue;
    end else if (count != 3'd0) begin
      // Counts down and then rests at zero
      count <= count - 3'd1;
    end
  end

  // High in the last wait cycle and whenever the counter is at rest
  assign waitDone = (count == 3'd0);

endmodule

/* sources.f */
+incdir+rtl
rtl/tim_pkg.sv
rtl/timControl.sv
rtl/waitCounter.sv
rtl/timArray.sv
rtl/dtim.sv
rtl/ahbDecoder.sv
rtl/timSubsystem.sv
test/timSubsystem_chk.sv
test/timSubsystem_tb.sv

/* test/timSubsystem_chk.sv */
/*
  Protocol checks bound into the data TIM. MaxLow is the longest run of low
  ready cycles that the bound slave may show. The error pair only matters where
  the bus response outputs are connected.
*/
`timescale 1ns/1ps
`include "tim_cfg.svh"

module timSubsystem_chk #(
  parameter int MaxLow = `TIM_WAIT_STATES
) (
  input logic HCLK,
  input logic HRESETn,
  input logic ready,
  input logic errFirstCyc,
  input logic errSecondCyc
);

  int lowRun;
  int assertFails;

  // Consecutive low ready cycles seen before the current edge
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      lowRun <= 0;
    end else if (ready) begin
      lowRun <= 0;
    end else begin
      lowRun <= lowRun + 1;
    end
  end

  // A low cycle is only allowed while the run is still below the limit
  lowLimit: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!ready) |-> (lowRun < MaxLow))
    else begin
      assertFails++;
      $error("Ready held low for more than %0d cycles", MaxLow);
    end

  readyAfterReset: assert property (@(posedge HCLK) $rose(HRESETn) |-> ready)
    else begin
      assertFails++;
      $error("Ready is low in the first cycle after reset");
    end

  // The ERROR response always takes both of its cycles
  errPair: assert property (@(posedge HCLK) disable iff (!HRESETn)
    errFirstCyc |=> errSecondCyc)
    else begin
      assertFails++;
      $error("ERROR first cycle not followed by the second cycle");
    end

endmodule

bind timControl timSubsystem_chk #(.MaxLow(`TIM_WAIT_STATES)) ctlChk_i (
  .HCLK         (HCLK),
  .HRESETn      (HRESETn),
  .ready        (readyOut),
  .errFirstCyc  (1'b0),
  .errSecondCyc (1'b0)
);

// The default slave needs one low cycle even with no TIM wait states
// The ERROR cycles are seen on the multiplexed response, as the master sees them
bind ahbDecoder timSubsystem_chk
  #(.MaxLow((`TIM_WAIT_STATES > 0) ? `TIM_WAIT_STATES : 1)) decChk_i (
  .HCLK         (HCLK),
  .HRESETn      (HRESETn),
  .ready        (HREADYOUT),
  .errFirstCyc  (HRESP & ~HREADYOUT),
  .errSecondCyc (HRESP & HREADYOUT)
);

/* test/timSubsystem_tb.sv */
/*
  Table-driven testbench for the data TIM subsystem. HREADY is tied back from
  HREADYOUT. Reads only target words the table has written before, since the
  array holds no defined value after reset.
*/
`timescale 1ns/1ps
`include "tim_cfg.svh"

module timSubsystem_tb;

  import tim_pkg::*;

  localparam int          ClkPeriod = 20;
  localparam int          Seed      = 50712;
  localparam logic [31:0] Base      = `TIM_BASE;

  // One bus transfer, with the idle cycles that come before it
  typedef struct {
    logic        wr;
    hTransT      trans;
    logic [31:0] addr;
    hSizeT       size;
    logic [31:0] data;
    logic        err;
    int          gap;
  } entryT;

  logic        HCLK;
  logic        HRESETn;
  logic        HSEL;
  logic [31:0] HADDR;
  logic        HWRITE;
  hTransT      HTRANS;
  hSizeT       HSIZE;
  logic [31:0] HWDATA;
  logic        HREADY;
  logic [31:0] HRDATA;
  logic        HREADYOUT;
  logic        HRESP;

  entryT       stimTable[$];
  logic [7:0]  refMem [`TIM_BYTES];
  int          cycleCount;
  int          cycleLimit;
  int          addrIdx;
  int          dataIdx;
  int          nextIdx;
  int          gapCount;
  int          lowCount;
  logic        rdy;
  logic        resp;
  logic [31:0] rdata;

  timSubsystem dut_i (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HTRANS    (HTRANS),
    .HSIZE     (HSIZE),
    .HWDATA    (HWDATA),
    .HREADY    (HREADY),
    .HRDATA    (HRDATA),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP)
  );

  // Single slave on the bus, so its ready is the bus ready
  assign HREADY = HREADYOUT;

  initial begin
    HCLK = 1'b0;
    forever #(ClkPeriod / 2) HCLK = ~HCLK;
  end

  always @(posedge HCLK) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the test table did not finish within %0d cycles", cycleLimit);
      stopRun();
    end
  end

  task automatic stopRun();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  ////////////////////////////////////////
  // Test table and reference model
  ////////////////////////////////////////

  function automatic void addEntry(input logic wr, input hTransT trans,
                                   input logic [31:0] addr, input hSizeT size,
                                   input logic err, input int gap);
    entryT e;
    e.wr    = wr;
    e.trans = trans;
    e.addr  = addr;
    e.size  = size;
    e.data  = $urandom;
    e.err   = err;
    e.gap   = gap;
    stimTable.push_back(e);
  endfunction

  function automatic void loadTable();
    // Word writes back to back, then reads after a gap
    addEntry(1'b1, transNonseq, Base + 32'h000, sizeWord, 1'b0, 0);
    addEntry(1'b1, transNonseq, Base + 32'h004, sizeWord, 1'b0, 0);
    addEntry(1'b1, transNonseq, Base + 32'h008, sizeWord, 1'b0, 0);
    addEntry(1'b1, transNonseq, Base + 32'hFFC, sizeWord, 1'b0, 0);
    addEntry(1'b0, transNonseq, Base + 32'h000, sizeWord, 1'b0, 1);
    addEntry(1'b0, transNonseq, Base + 32'h004, sizeWord, 1'b0, 0);
    addEntry(1'b0, transNonseq, Base + 32'hFFC, sizeWord, 1'b0, 1);
    // Partial writes merge into words already written
    addEntry(1'b1, transNonseq, Base + 32'h009, sizeByte, 1'b0, 1);
    addEntry(1'b1, transNonseq, Base + 32'h00B, sizeByte, 1'b0, 0);
    addEntry(1'b1, transNonseq, Base + 32'h006, sizeHalf, 1'b0, 0);
    addEntry(1'b1, transNonseq, Base + 32'h000, sizeHalf, 1'b0, 1);
    addEntry(1'b0, transNonseq, Base + 32'h008, sizeWord, 1'b0, 0);
    addEntry(1'b0, transNonseq, Base + 32'h004, sizeWord, 1'b0, 0);
    addEntry(1'b0, transNonseq, Base + 32'h000, sizeWord, 1'b0, 0);
    // Read straight after a write to the same word
    addEntry(1'b1, transNonseq, Base + 32'h010, sizeWord, 1'b0, 1);
    addEntry(1'b0, transNonseq, Base + 32'h010, sizeWord, 1'b0, 0);
    addEntry(1'b1, transNonseq, Base + 32'h011, sizeByte, 1'b0, 0);
    addEntry(1'b0, transNonseq, Base + 32'h010, sizeWord, 1'b0, 0);
    addEntry(1'b1, transNonseq, Base + 32'h012, sizeHalf, 1'b0, 0);
    addEntry(1'b0, transNonseq, Base + 32'h010, sizeWord, 1'b0, 0);
    // Outside the window, two of them alias word 0 if decoded wrongly
    addEntry(1'b1, transNonseq, 32'h8000_1000, sizeWord, 1'b1, 1);
    addEntry(1'b1, transNonseq, 32'h0000_0000, sizeWord, 1'b1, 0);
    addEntry(1'b0, transNonseq, Base + 32'h000, sizeWord, 1'b0, 0);
    addEntry(1'b1, transNonseq, 32'h7FFF_FFFC, sizeWord, 1'b1, 0);
    addEntry(1'b0, transNonseq, 32'hFFFF_FFF0, sizeWord, 1'b1, 0);
    addEntry(1'b0, transNonseq, Base + 32'hFFC, sizeWord, 1'b0, 0);
    // IDLE and BUSY with a write direction must leave the memory alone
    addEntry(1'b1, transIdle,   Base + 32'h004, sizeWord, 1'b0, 1);
    addEntry(1'b1, transBusy,   Base + 32'h004, sizeWord, 1'b0, 0);
    addEntry(1'b0, transNonseq, Base + 32'h004, sizeWord, 1'b0, 0);
    addEntry(1'b1, transSeq,    Base + 32'h014, sizeWord, 1'b0, 0);
    addEntry(1'b0, transSeq,    Base + 32'h014, sizeWord, 1'b0, 0);
  endfunction

  // N bytes cover the N-aligned block, byte lane b carries address bits 1:0 == b
  function automatic void refWrite(input logic [31:0] addr, input hSizeT size,
                                   input logic [31:0] data);
    int nBytes;
    int first;
    nBytes = 1 << int'(size);
    first  = (addr - Base) & ~(nBytes - 1);
    for (int b = first; b < first + nBytes; b++) begin
      refMem[b] = data[8*(b%4) +: 8];
    end
  endfunction

  function automatic logic [31:0] refRead(input logic [31:0] addr);
    int w;
    w = (addr - Base) & ~3;
    return {refMem[w+3], refMem[w+2], refMem[w+1], refMem[w]};
  endfunction

  ////////////////////////////////////////
  // Bus master
  ////////////////////////////////////////

  // Puts the next entry on the address phase, or an idle cycle
  task automatic driveAddress();
    entryT e;
    if (nextIdx < stimTable.size() && gapCount >= stimTable[nextIdx].gap) begin
      e = stimTable[nextIdx];
      HSEL   <= 1'b1;
      HADDR  <= e.addr;
      HWRITE <= e.wr;
      HTRANS <= e.trans;
      HSIZE  <= e.size;
      addrIdx = nextIdx;
      nextIdx++;
      gapCount = 0;
    end else begin
      HSEL   <= 1'b0;
      HTRANS <= transIdle;
      addrIdx = -1;
      gapCount++;
    end
  endtask

  // Checks the ready cycle that closes a data phase
  task automatic checkCompletion(input int idx);
    entryT       e;
    int          expLow;
    logic [31:0] expData;
    e      = stimTable[idx];
    expLow = e.err ? 1 : int'(`TIM_WAIT_STATES);
    assert (lowCount == expLow) else begin
      $display("[ERROR] HREADYOUT low cycles, entry %0d: got %h expected %h",
               idx, lowCount, expLow);
      stopRun();
    end
    assert (resp === e.err) else begin
      $display("[ERROR] HRESP, entry %0d: got %h expected %h", idx, resp, e.err);
      stopRun();
    end
    if (!e.err && e.wr) begin
      refWrite(e.addr, e.size, e.data);
    end else if (!e.err) begin
      expData = refRead(e.addr);
      assert (rdata === expData) else begin
        $display("[ERROR] HRDATA, entry %0d: got %h expected %h", idx, rdata, expData);
        stopRun();
      end
    end
  endtask

  initial begin
    void'($urandom(Seed));
    HRESETn    = 1'b0;
    HSEL       = 1'b0;
    HADDR      = 32'h0;
    HWRITE     = 1'b0;
    HTRANS     = transIdle;
    HSIZE      = sizeWord;
    HWDATA     = 32'h0;
    addrIdx    = -1;
    dataIdx    = -1;
    nextIdx    = 0;
    gapCount   = 0;
    lowCount   = 0;
    cycleCount = 0;
    loadTable();
    cycleLimit = stimTable.size() * (`TIM_WAIT_STATES + 3) + 20;
    repeat (2) @(posedge HCLK);
    HRESETn <= 1'b1;
    driveAddress();
    while (nextIdx < stimTable.size() || addrIdx >= 0 || dataIdx >= 0) begin
      // Outputs are sampled mid-cycle, the master moves on the next rising edge
      @(negedge HCLK);
      rdy   = HREADYOUT;
      resp  = HRESP;
      rdata = HRDATA;
      assert (!$isunknown(rdy)) else begin
        $display("HREADYOUT is unknown in the middle of a bus cycle");
        stopRun();
      end
      if (dataIdx < 0) begin
        assert (rdy === 1'b1 && resp === 1'b0) else begin
          $display("[ERROR] HREADYOUT/HRESP with no transfer: got %h/%h expected 1/0",
                   rdy, resp);
          stopRun();
        end
      end else if (!rdy) begin
        lowCount++;
        assert (resp === stimTable[dataIdx].err) else begin
          $display("[ERROR] HRESP in wait cycle, entry %0d: got %h expected %h",
                   dataIdx, resp, stimTable[dataIdx].err);
          stopRun();
        end
      end else begin
        checkCompletion(dataIdx);
      end
      @(posedge HCLK);
      if (rdy) begin
        // The address phase just ended, a real transfer starts its data phase
        dataIdx  = -1;
        lowCount = 0;
        if (addrIdx >= 0 && (stimTable[addrIdx].trans == transNonseq ||
                             stimTable[addrIdx].trans == transSeq)) begin
          dataIdx = addrIdx;
          if (stimTable[dataIdx].wr) begin
            HWDATA <= stimTable[dataIdx].data;
          end
        end
        driveAddress();
      end
    end
    repeat (2) @(posedge HCLK);
    if (dut_i.dtim_i.control_i.ctlChk_i.assertFails == 0 &&
        dut_i.decoder_i.decChk_i.assertFails == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Protocol assertions failed during the run");
      stopRun();
    end
  end

endmodule
